// ==== apu_cluster_pkg.sv ====
// Shared sizes, opcodes and bus structs of the auxiliary processing unit cluster
// Imported by every RTL module and by the testbench
package apu_cluster_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Cluster sizes
   ////////////////////////////////////////////////////////////////////////////

   localparam int NB_CORES      = 4;
   localparam int NB_PIPE_UNITS = 2;
   localparam int NB_DIV_UNITS  = 1;
   localparam int DATA_W        = 32;

   // Core index tag, NB_CORES must equal 2**CORE_ID_W
   localparam int CORE_ID_W     = 2;

   // One quotient bit per iteration
   localparam int DIV_STEPS     = DATA_W;
   localparam int DIV_CNT_W     = $clog2(DIV_STEPS + 1);

   ////////////////////////////////////////////////////////////////////////////
   // Encodings
   ////////////////////////////////////////////////////////////////////////////

   typedef enum logic {
      UNIT_PIPE,
      UNIT_DIV
   } unit_type_e;

   // Min and max compare signed, divide and remainder are unsigned
   typedef enum logic [2:0] {
      OP_ADD,
      OP_SUB,
      OP_MIN,
      OP_MAX,
      OP_DIVU,
      OP_REMU
   } apu_op_e;

   ////////////////////////////////////////////////////////////////////////////
   // Bus payloads
   ////////////////////////////////////////////////////////////////////////////

   typedef struct packed {
      logic ov;   // signed overflow of add or sub
      logic dz;   // divide by zero
      logic nv;   // op not valid for this unit
   } apu_flags_t;

   typedef struct packed {
      apu_op_e           op;
      logic [DATA_W-1:0] operand_a;
      logic [DATA_W-1:0] operand_b;
   } apu_req_t;

   typedef struct packed {
      logic [DATA_W-1:0] data;
      apu_flags_t        flags;
   } apu_rsp_t;

   // Unit side carries the index of the issuing core
   typedef struct packed {
      apu_req_t             req;
      logic [CORE_ID_W-1:0] core_id;
   } unit_req_t;

   typedef struct packed {
      apu_rsp_t             rsp;
      logic [CORE_ID_W-1:0] core_id;
   } unit_rsp_t;

endpackage

// ==== apu_demux.sv ====
// Per-core router between a core port and the two unit classes
// Holds one request in flight and keeps the response until the core reads it
`timescale 1ns/100ps

module apu_demux
(
   input  logic                       clk,
   input  logic                       arst_n_i,

   // Core side
   input  logic                       core_req_i,
   output logic                       core_gnt_o,
   input  apu_cluster_pkg::unit_type_e core_type_i,
   input  apu_cluster_pkg::apu_req_t  core_data_i,
   output logic                       core_rvalid_o,
   input  logic                       core_rready_i,
   output apu_cluster_pkg::apu_rsp_t  core_rdata_o,

   // Crossbar side
   output logic                       pipe_req_o,
   input  logic                       pipe_gnt_i,
   output logic                       div_req_o,
   input  logic                       div_gnt_i,
   output apu_cluster_pkg::apu_req_t  req_data_o,
   input  logic                       pipe_rvalid_i,
   input  logic                       div_rvalid_i,
   input  apu_cluster_pkg::apu_rsp_t  pipe_rsp_i,
   input  apu_cluster_pkg::apu_rsp_t  div_rsp_i
);
   import apu_cluster_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_WAIT,
      ST_HOLD
   } demux_state_e;

   demux_state_e state_q;
   demux_state_e state_d;
   apu_rsp_t     rsp_q;
   logic         idle;
   logic         unit_rvalid;

   assign idle        = (state_q == ST_IDLE);
   assign unit_rvalid = pipe_rvalid_i | div_rvalid_i;

   // Only an idle core may issue, and only to the class named by its type
   assign pipe_req_o  = core_req_i & idle & (core_type_i == UNIT_PIPE);
   assign div_req_o   = core_req_i & idle & (core_type_i == UNIT_DIV);
   assign req_data_o  = core_data_i;
   assign core_gnt_o  = (pipe_req_o & pipe_gnt_i) | (div_req_o & div_gnt_i);

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         ST_IDLE:
            if (core_gnt_o)
               state_d = ST_WAIT;
         ST_WAIT:
            if (unit_rvalid)
               state_d = ST_HOLD;
         default:
            if (core_rready_i)
               state_d = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
         state_q <= ST_IDLE;
      else
         state_q <= state_d;
   end

   // Units never stall, so the answer is captured the cycle it shows up
   always_ff @(posedge clk)
   begin
      if ((state_q == ST_WAIT) && unit_rvalid)
         rsp_q <= pipe_rvalid_i ? pipe_rsp_i : div_rsp_i;
   end

   assign core_rvalid_o = (state_q == ST_HOLD);
   assign core_rdata_o  = rsp_q;

endmodule

// ==== apu_xbar.sv ====
// Round-robin crossbar from all cores to a pool of identical units
// Tags each granted request with the core index and routes answers back by tag
`timescale 1ns/100ps

module apu_xbar
#(
   parameter int NB_UNITS = 1
)
(
   input  logic                                                     clk,
   input  logic                                                     arst_n_i,

   // Core side, one entry per demux
   input  logic [apu_cluster_pkg::NB_CORES-1:0]                     slv_req_i,
   output logic [apu_cluster_pkg::NB_CORES-1:0]                     slv_gnt_o,
   input  apu_cluster_pkg::apu_req_t [apu_cluster_pkg::NB_CORES-1:0] slv_data_i,
   output logic [apu_cluster_pkg::NB_CORES-1:0]                     slv_rvalid_o,
   output apu_cluster_pkg::apu_rsp_t [apu_cluster_pkg::NB_CORES-1:0] slv_rsp_o,

   // Unit side
   output logic [NB_UNITS-1:0]                                      mst_req_o,
   input  logic [NB_UNITS-1:0]                                      mst_gnt_i,
   output apu_cluster_pkg::unit_req_t [NB_UNITS-1:0]                mst_data_o,
   input  logic [NB_UNITS-1:0]                                      mst_rvalid_i,
   input  apu_cluster_pkg::unit_rsp_t [NB_UNITS-1:0]                mst_rsp_i
);
   import apu_cluster_pkg::*;

   logic [CORE_ID_W-1:0] rr_ptr_q;
   logic [CORE_ID_W-1:0] rr_ptr_d;

   ////////////////////////////////////////////////////////////////////////////
   // Request path
   ////////////////////////////////////////////////////////////////////////////

   // Cores are scanned from the pointer, each takes the first free unit
   always_comb
   begin
      logic [NB_UNITS-1:0]  free;
      logic [CORE_ID_W-1:0] idx;
      logic                 placed;

      free       = mst_gnt_i;
      slv_gnt_o  = '0;
      mst_req_o  = '0;
      mst_data_o = '0;
      rr_ptr_d   = rr_ptr_q;

      for (int k = 0; k < NB_CORES; k++)
      begin
         // Wraps for free since the core count is a power of two
         idx    = rr_ptr_q + CORE_ID_W'(k);
         placed = 1'b0;
         for (int u = 0; u < NB_UNITS; u++)
         begin
            if (slv_req_i[idx] && free[u] && !placed)
            begin
               placed                = 1'b1;
               free[u]               = 1'b0;
               mst_req_o[u]          = 1'b1;
               mst_data_o[u].req     = slv_data_i[idx];
               mst_data_o[u].core_id = idx;
               slv_gnt_o[idx]        = 1'b1;
               rr_ptr_d              = idx + 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
         rr_ptr_q <= '0;
      else
         rr_ptr_q <= rr_ptr_d;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Response path
   ////////////////////////////////////////////////////////////////////////////

   // One request per core in flight, so tags never collide
   always_comb
   begin
      slv_rvalid_o = '0;
      slv_rsp_o    = '0;
      for (int u = 0; u < NB_UNITS; u++)
      begin
         if (mst_rvalid_i[u])
         begin
            slv_rvalid_o[mst_rsp_i[u].core_id] = 1'b1;
            slv_rsp_o[mst_rsp_i[u].core_id]    = mst_rsp_i[u].rsp;
         end
      end
   end

endmodule

// ==== apu_pipe_unit.sv ====
// Two-stage integer unit for add, sub, signed min and signed max
// Accepts a request every cycle, answers two cycles later
`timescale 1ns/100ps

module apu_pipe_unit
(
   input  logic                       clk,
   input  logic                       arst_n_i,
   input  logic                       req_i,
   output logic                       gnt_o,
   input  apu_cluster_pkg::unit_req_t req_data_i,
   output logic                       rvalid_o,
   output apu_cluster_pkg::unit_rsp_t rsp_o
);
   import apu_cluster_pkg::*;

   logic [DATA_W-1:0] op_a;
   logic [DATA_W-1:0] op_b;
   logic [DATA_W-1:0] sum;
   logic [DATA_W-1:0] diff;
   logic              a_lt_b;
   unit_rsp_t         s1_rsp_d;
   unit_rsp_t         s1_rsp_q;
   unit_rsp_t         s2_rsp_q;
   logic              s1_valid_q;
   logic              s2_valid_q;

   assign gnt_o  = 1'b1;
   assign op_a   = req_data_i.req.operand_a;
   assign op_b   = req_data_i.req.operand_b;
   assign sum    = op_a + op_b;
   assign diff   = op_a - op_b;
   assign a_lt_b = $signed(op_a) < $signed(op_b);

   // Stage one
   always_comb
   begin
      s1_rsp_d         = '0;
      s1_rsp_d.core_id = req_data_i.core_id;
      case (req_data_i.req.op)
         OP_ADD:
         begin
            s1_rsp_d.rsp.data     = sum;
            s1_rsp_d.rsp.flags.ov = (op_a[DATA_W-1] == op_b[DATA_W-1]) &&
                                    (sum[DATA_W-1] != op_a[DATA_W-1]);
         end
         OP_SUB:
         begin
            s1_rsp_d.rsp.data     = diff;
            s1_rsp_d.rsp.flags.ov = (op_a[DATA_W-1] != op_b[DATA_W-1]) &&
                                    (diff[DATA_W-1] != op_a[DATA_W-1]);
         end
         OP_MIN:  s1_rsp_d.rsp.data = a_lt_b ? op_a : op_b;
         OP_MAX:  s1_rsp_d.rsp.data = a_lt_b ? op_b : op_a;
         default: s1_rsp_d.rsp.flags.nv = 1'b1;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         s1_valid_q <= 1'b0;
         s2_valid_q <= 1'b0;
      end
      else
      begin
         s1_valid_q <= req_i;
         s2_valid_q <= s1_valid_q;
      end
   end

   // Stage two
   always_ff @(posedge clk)
   begin
      if (req_i)
         s1_rsp_q <= s1_rsp_d;
      if (s1_valid_q)
         s2_rsp_q <= s1_rsp_q;
   end

   assign rvalid_o = s2_valid_q;
   assign rsp_o    = s2_rsp_q;

endmodule

// ==== apu_div_unit.sv ====
// Iterative unsigned divider, restoring shift-subtract, one quotient bit a cycle
// Takes a new request only when idle, answers DIV_STEPS+1 cycles after acceptance
`timescale 1ns/100ps

module apu_div_unit
(
   input  logic                       clk,
   input  logic                       arst_n_i,
   input  logic                       req_i,
   output logic                       gnt_o,
   input  apu_cluster_pkg::unit_req_t req_data_i,
   output logic                       rvalid_o,
   output apu_cluster_pkg::unit_rsp_t rsp_o
);
   import apu_cluster_pkg::*;

   logic                 busy_q;
   logic                 rvalid_q;
   logic [DIV_CNT_W-1:0] cnt_q;
   logic                 accept;
   logic                 last_step;
   apu_op_e              op_q;
   logic [CORE_ID_W-1:0] core_id_q;
   logic [DATA_W-1:0]    divisor_q;
   logic [DATA_W-1:0]    quo_q;
   logic [DATA_W-1:0]    rem_q;
   logic [DATA_W:0]      rem_shift;
   logic [DATA_W:0]      trial;
   logic [DATA_W-1:0]    quo_next;
   logic [DATA_W-1:0]    rem_next;
   unit_rsp_t            rsp_d;
   unit_rsp_t            rsp_q;

   assign gnt_o     = !busy_q;
   assign accept    = req_i & gnt_o;
   assign last_step = busy_q && (cnt_q == DIV_CNT_W'(1));

   // Dividend bits shift out of quo_q into the remainder
   assign rem_shift = {rem_q, quo_q[DATA_W-1]};
   assign trial     = rem_shift - {1'b0, divisor_q};
   assign quo_next  = {quo_q[DATA_W-2:0], !trial[DATA_W]};
   assign rem_next  = trial[DATA_W] ? rem_shift[DATA_W-1:0] : trial[DATA_W-1:0];

   // Zero divisor falls out of the algorithm as all ones and the dividend
   always_comb
   begin
      rsp_d         = '0;
      rsp_d.core_id = core_id_q;
      case (op_q)
         OP_DIVU:
         begin
            rsp_d.rsp.data     = quo_next;
            rsp_d.rsp.flags.dz = (divisor_q == '0);
         end
         OP_REMU:
         begin
            rsp_d.rsp.data     = rem_next;
            rsp_d.rsp.flags.dz = (divisor_q == '0);
         end
         default: rsp_d.rsp.flags.nv = 1'b1;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         busy_q   <= 1'b0;
         rvalid_q <= 1'b0;
         cnt_q    <= '0;
      end
      else
      begin
         rvalid_q <= last_step;
         if (accept)
         begin
            busy_q <= 1'b1;
            cnt_q  <= DIV_CNT_W'(DIV_STEPS);
         end
         else if (busy_q)
         begin
            cnt_q <= cnt_q - 1'b1;
            if (last_step)
               busy_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         op_q      <= req_data_i.req.op;
         core_id_q <= req_data_i.core_id;
         divisor_q <= req_data_i.req.operand_b;
         quo_q     <= req_data_i.req.operand_a;
         rem_q     <= '0;
      end
      else if (busy_q)
      begin
         quo_q <= quo_next;
         rem_q <= rem_next;
      end
      if (last_step)
         rsp_q <= rsp_d;
   end

   assign rvalid_o = rvalid_q;
   assign rsp_o    = rsp_q;

endmodule

// ==== shared_apu_cluster.sv ====
// Shared arithmetic cluster, per-core demuxes feeding one crossbar per unit class
// Pipelined units answer 3 cycles after grant, the divider DIV_STEPS+2 cycles
`timescale 1ns/100ps

module shared_apu_cluster
(
   input  logic                                                      clk,
   input  logic                                                      arst_n_i,

   input  logic [apu_cluster_pkg::NB_CORES-1:0]                      core_req_i,
   output logic [apu_cluster_pkg::NB_CORES-1:0]                      core_gnt_o,
   input  apu_cluster_pkg::unit_type_e [apu_cluster_pkg::NB_CORES-1:0] core_type_i,
   input  apu_cluster_pkg::apu_req_t [apu_cluster_pkg::NB_CORES-1:0]  core_data_i,
   output logic [apu_cluster_pkg::NB_CORES-1:0]                      core_rvalid_o,
   input  logic [apu_cluster_pkg::NB_CORES-1:0]                      core_rready_i,
   output apu_cluster_pkg::apu_rsp_t [apu_cluster_pkg::NB_CORES-1:0]  core_rdata_o
);
   import apu_cluster_pkg::*;

   // Demux to crossbar, indexed by core
   logic      [NB_CORES-1:0]      pipe_req;
   logic      [NB_CORES-1:0]      pipe_gnt;
   logic      [NB_CORES-1:0]      pipe_rvalid;
   logic      [NB_CORES-1:0]      div_req;
   logic      [NB_CORES-1:0]      div_gnt;
   logic      [NB_CORES-1:0]      div_rvalid;
   apu_req_t  [NB_CORES-1:0]      req_data;
   apu_rsp_t  [NB_CORES-1:0]      pipe_rsp;
   apu_rsp_t  [NB_CORES-1:0]      div_rsp;

   // Crossbar to units
   logic      [NB_PIPE_UNITS-1:0] pu_req;
   logic      [NB_PIPE_UNITS-1:0] pu_gnt;
   logic      [NB_PIPE_UNITS-1:0] pu_rvalid;
   unit_req_t [NB_PIPE_UNITS-1:0] pu_data;
   unit_rsp_t [NB_PIPE_UNITS-1:0] pu_rsp;
   logic      [NB_DIV_UNITS-1:0]  du_req;
   logic      [NB_DIV_UNITS-1:0]  du_gnt;
   logic      [NB_DIV_UNITS-1:0]  du_rvalid;
   unit_req_t [NB_DIV_UNITS-1:0]  du_data;
   unit_rsp_t [NB_DIV_UNITS-1:0]  du_rsp;

   for (genvar i = 0; i < NB_CORES; i++)
   begin : g_demux
      apu_demux i_apu_demux
      (
         .clk           ( clk              ),
         .arst_n_i      ( arst_n_i         ),
         .core_req_i    ( core_req_i[i]    ),
         .core_gnt_o    ( core_gnt_o[i]    ),
         .core_type_i   ( core_type_i[i]   ),
         .core_data_i   ( core_data_i[i]   ),
         .core_rvalid_o ( core_rvalid_o[i] ),
         .core_rready_i ( core_rready_i[i] ),
         .core_rdata_o  ( core_rdata_o[i]  ),
         .pipe_req_o    ( pipe_req[i]      ),
         .pipe_gnt_i    ( pipe_gnt[i]      ),
         .div_req_o     ( div_req[i]       ),
         .div_gnt_i     ( div_gnt[i]       ),
         .req_data_o    ( req_data[i]      ),
         .pipe_rvalid_i ( pipe_rvalid[i]   ),
         .div_rvalid_i  ( div_rvalid[i]    ),
         .pipe_rsp_i    ( pipe_rsp[i]      ),
         .div_rsp_i     ( div_rsp[i]       )
      );
   end

   ////////////////////////////////////////////////////////////////////////////
   // Pipelined class
   ////////////////////////////////////////////////////////////////////////////

   apu_xbar #(.NB_UNITS(NB_PIPE_UNITS)) i_pipe_xbar
   (
      .clk          ( clk         ),
      .arst_n_i     ( arst_n_i    ),
      .slv_req_i    ( pipe_req    ),
      .slv_gnt_o    ( pipe_gnt    ),
      .slv_data_i   ( req_data    ),
      .slv_rvalid_o ( pipe_rvalid ),
      .slv_rsp_o    ( pipe_rsp    ),
      .mst_req_o    ( pu_req      ),
      .mst_gnt_i    ( pu_gnt      ),
      .mst_data_o   ( pu_data     ),
      .mst_rvalid_i ( pu_rvalid   ),
      .mst_rsp_i    ( pu_rsp      )
   );

   for (genvar j = 0; j < NB_PIPE_UNITS; j++)
   begin : g_pipe_unit
      apu_pipe_unit i_apu_pipe_unit
      (
         .clk        ( clk          ),
         .arst_n_i   ( arst_n_i     ),
         .req_i      ( pu_req[j]    ),
         .gnt_o      ( pu_gnt[j]    ),
         .req_data_i ( pu_data[j]   ),
         .rvalid_o   ( pu_rvalid[j] ),
         .rsp_o      ( pu_rsp[j]    )
      );
   end

   ////////////////////////////////////////////////////////////////////////////
   // Divide class
   ////////////////////////////////////////////////////////////////////////////

   apu_xbar #(.NB_UNITS(NB_DIV_UNITS)) i_div_xbar
   (
      .clk          ( clk        ),
      .arst_n_i     ( arst_n_i   ),
      .slv_req_i    ( div_req    ),
      .slv_gnt_o    ( div_gnt    ),
      .slv_data_i   ( req_data   ),
      .slv_rvalid_o ( div_rvalid ),
      .slv_rsp_o    ( div_rsp    ),
      .mst_req_o    ( du_req     ),
      .mst_gnt_i    ( du_gnt     ),
      .mst_data_o   ( du_data    ),
      .mst_rvalid_i ( du_rvalid  ),
      .mst_rsp_i    ( du_rsp     )
   );

   for (genvar j = 0; j < NB_DIV_UNITS; j++)
   begin : g_div_unit
      apu_div_unit i_apu_div_unit
      (
         .clk        ( clk          ),
         .arst_n_i   ( arst_n_i     ),
         .req_i      ( du_req[j]    ),
         .gnt_o      ( du_gnt[j]    ),
         .req_data_i ( du_data[j]   ),
         .rvalid_o   ( du_rvalid[j] ),
         .rsp_o      ( du_rsp[j]    )
      );
   end

endmodule

// ==== tb_checker.sv ====
// Response checker for the cluster's core ports
// Queues the expected answer of each granted request and compares every response with it
`timescale 1ns/100ps

module tb_checker
(
   input  logic                                                      clk,
   input  logic                                                      arst_n_i,
   input  logic [apu_cluster_pkg::NB_CORES-1:0]                      core_req_i,
   input  logic [apu_cluster_pkg::NB_CORES-1:0]                      core_gnt_i,
   input  logic [apu_cluster_pkg::NB_CORES-1:0]                      core_rvalid_i,
   input  logic [apu_cluster_pkg::NB_CORES-1:0]                      core_rready_i,
   input  apu_cluster_pkg::apu_rsp_t [apu_cluster_pkg::NB_CORES-1:0] core_rdata_i,
   input  apu_cluster_pkg::apu_rsp_t [apu_cluster_pkg::NB_CORES-1:0] exp_rsp_i,
   output int                                                        error_count_o,
   output int                                                        rsp_count_o
);
   import apu_cluster_pkg::*;

   apu_rsp_t exp_q [NB_CORES][$];
   int       errors    = 0;
   int       rsp_count = 0;

   assign error_count_o = errors;
   assign rsp_count_o   = rsp_count;

   // Inputs only move just after the rising edge, so the falling edge
   // shows what the next rising edge will transfer
   always @(negedge clk)
   begin
      apu_rsp_t expected;
      if (arst_n_i)
      begin
         for (int c = 0; c < NB_CORES; c++)
         begin
            if (core_gnt_i[c] && !core_req_i[c])
            begin
               errors++;
               $display("%0t core %0d was granted without a request", $time, c);
            end

            if (core_rvalid_i[c] && (exp_q[c].size() == 0))
            begin
               errors++;
               $display("%0t core %0d shows a response with no request outstanding",
                        $time, c);
            end
            else if (core_rvalid_i[c] && core_rready_i[c])
            begin
               expected = exp_q[c].pop_front();
               rsp_count++;
               if (core_rdata_i[c].data !== expected.data)
               begin
                  errors++;
                  $display("MISMATCH %0t core_rdata_o[%0d].data expected %h actual %h",
                           $time, c, expected.data, core_rdata_i[c].data);
               end
               if (core_rdata_i[c].flags !== expected.flags)
               begin
                  errors++;
                  $display("MISMATCH %0t core_rdata_o[%0d].flags expected %b actual %b",
                           $time, c, expected.flags, core_rdata_i[c].flags);
               end
            end

            // A held response must block the next grant of its core
            if (core_req_i[c] && core_gnt_i[c])
            begin
               if (exp_q[c].size() != 0)
               begin
                  errors++;
                  $display("%0t core %0d was granted while its earlier request was open",
                           $time, c);
               end
               exp_q[c].push_back(exp_rsp_i[c]);
            end
         end
      end
   end

endmodule

// ==== tb_assertions.sv ====
// Handshake rules of the core ports and the divide unit
// Attached to shared_apu_cluster with bind
`timescale 1ns/100ps

module tb_assertions
(
   input  logic                                                      clk,
   input  logic                                                      arst_n_i,
   input  logic [apu_cluster_pkg::NB_CORES-1:0]                      core_req_i,
   input  logic [apu_cluster_pkg::NB_CORES-1:0]                      core_gnt_i,
   input  logic [apu_cluster_pkg::NB_CORES-1:0]                      core_rvalid_i,
   input  logic [apu_cluster_pkg::NB_CORES-1:0]                      core_rready_i,
   input  apu_cluster_pkg::apu_rsp_t [apu_cluster_pkg::NB_CORES-1:0] core_rdata_i,
   input  logic                                                      div_req_i,
   input  logic                                                      div_gnt_i,
   input  logic                                                      div_rvalid_i
);
   import apu_cluster_pkg::*;

   int fail_count = 0;

   a_gnt_needs_req : assert property (@(posedge clk) disable iff (!arst_n_i)
      (core_gnt_i & ~core_req_i) == '0)
   else
   begin
      fail_count++;
      $error("core grant raised without a request");
   end

   // Response stays put until the core takes it
   for (genvar c = 0; c < NB_CORES; c++)
   begin : g_core
      a_rsp_stable : assert property (@(posedge clk) disable iff (!arst_n_i)
         core_rvalid_i[c] && !core_rready_i[c] |=>
            core_rvalid_i[c] && $stable(core_rdata_i[c]))
      else
      begin
         fail_count++;
         $error("core %0d response dropped or changed before rready", c);
      end
   end

   // Divider is busy from an accepted request until its answer comes out
   a_div_no_gnt_busy : assert property (@(posedge clk) disable iff (!arst_n_i)
      div_req_i && div_gnt_i |=> !div_gnt_i)
   else
   begin
      fail_count++;
      $error("divide unit granted right after accepting a request");
   end

   a_div_busy_until_rsp : assert property (@(posedge clk) disable iff (!arst_n_i)
      !div_gnt_i |=> !div_gnt_i || div_rvalid_i)
   else
   begin
      fail_count++;
      $error("divide unit granted again before returning its result");
   end

endmodule

bind shared_apu_cluster tb_assertions i_tb_assertions
(
   .clk           ( clk           ),
   .arst_n_i      ( arst_n_i      ),
   .core_req_i    ( core_req_i    ),
   .core_gnt_i    ( core_gnt_o    ),
   .core_rvalid_i ( core_rvalid_o ),
   .core_rready_i ( core_rready_i ),
   .core_rdata_i  ( core_rdata_o  ),
   .div_req_i     ( du_req[0]     ),
   .div_gnt_i     ( du_gnt[0]     ),
   .div_rvalid_i  ( du_rvalid[0]  )
);

// ==== tb_shared_apu_cluster.sv ====
// Testbench for the shared arithmetic cluster
// Four cores run a table of requests at once while random stalls hold their responses
`timescale 1ns/100ps

module tb_shared_apu_cluster;
   import apu_cluster_pkg::*;

   localparam int          CLK_PERIOD     = 100;
   localparam int          DRIVE_DELAY    = 10;
   localparam int          RESET_CYCLES   = 5;
   localparam int          TIMEOUT_CYCLES = 2000;
   localparam int          NB_ENTRIES     = 24;
   localparam logic [15:0] LFSR_SEED      = 16'd83;

   typedef struct packed {
      logic [CORE_ID_W-1:0] core;
      unit_type_e           utype;
      apu_op_e              op;
      logic [DATA_W-1:0]    operand_a;
      logic [DATA_W-1:0]    operand_b;
      logic [DATA_W-1:0]    exp_data;
      apu_flags_t           exp_flags;
   } entry_t;

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus table, rows of one core run in order, flags are {ov, dz, nv}
   ////////////////////////////////////////////////////////////////////////////

   localparam entry_t STIM [NB_ENTRIES] = '{
      '{2'd0, UNIT_PIPE, OP_ADD,  32'h0000_0005, 32'h0000_0007, 32'h0000_000C, 3'b000},
      '{2'd0, UNIT_DIV,  OP_DIVU, 32'h0000_0064, 32'h0000_0007, 32'h0000_000E, 3'b000},
      '{2'd0, UNIT_PIPE, OP_ADD,  32'h7FFF_FFFF, 32'h0000_0001, 32'h8000_0000, 3'b100},
      '{2'd0, UNIT_PIPE, OP_MIN,  32'hFFFF_FFFF, 32'h0000_0001, 32'hFFFF_FFFF, 3'b000},
      '{2'd0, UNIT_DIV,  OP_REMU, 32'h0000_0064, 32'h0000_0007, 32'h0000_0002, 3'b000},
      '{2'd0, UNIT_PIPE, OP_DIVU, 32'h0000_0001, 32'h0000_0001, 32'h0000_0000, 3'b001},
      '{2'd1, UNIT_DIV,  OP_DIVU, 32'hFFFF_FFFF, 32'h0000_0010, 32'h0FFF_FFFF, 3'b000},
      '{2'd1, UNIT_PIPE, OP_SUB,  32'h8000_0000, 32'h0000_0001, 32'h7FFF_FFFF, 3'b100},
      '{2'd1, UNIT_PIPE, OP_MAX,  32'h8000_0000, 32'h7FFF_FFFF, 32'h7FFF_FFFF, 3'b000},
      '{2'd1, UNIT_DIV,  OP_DIVU, 32'h1234_5678, 32'h0000_0000, 32'hFFFF_FFFF, 3'b010},
      '{2'd1, UNIT_PIPE, OP_SUB,  32'h0000_0003, 32'h0000_0005, 32'hFFFF_FFFE, 3'b000},
      '{2'd1, UNIT_DIV,  OP_ADD,  32'h0000_0002, 32'h0000_0003, 32'h0000_0000, 3'b001},
      '{2'd2, UNIT_DIV,  OP_REMU, 32'h1234_5678, 32'h0000_0000, 32'h1234_5678, 3'b010},
      '{2'd2, UNIT_PIPE, OP_ADD,  32'hFFFF_FFFF, 32'h0000_0001, 32'h0000_0000, 3'b000},
      '{2'd2, UNIT_PIPE, OP_MIN,  32'h8000_0000, 32'h0000_0000, 32'h8000_0000, 3'b000},
      '{2'd2, UNIT_DIV,  OP_DIVU, 32'hDEAD_BEEF, 32'h0000_0001, 32'hDEAD_BEEF, 3'b000},
      '{2'd2, UNIT_PIPE, OP_MAX,  32'hFFFF_FFFE, 32'hFFFF_FFFD, 32'hFFFF_FFFE, 3'b000},
      '{2'd2, UNIT_PIPE, OP_ADD,  32'h8000_0000, 32'h8000_0000, 32'h0000_0000, 3'b100},
      '{2'd3, UNIT_DIV,  OP_DIVU, 32'h0000_0007, 32'h0000_0064, 32'h0000_0000, 3'b000},
      '{2'd3, UNIT_DIV,  OP_REMU, 32'h0000_0007, 32'h0000_0064, 32'h0000_0007, 3'b000},
      '{2'd3, UNIT_PIPE, OP_SUB,  32'h0000_0000, 32'h8000_0000, 32'h8000_0000, 3'b100},
      '{2'd3, UNIT_PIPE, OP_MAX,  32'h0000_0005, 32'h0000_0005, 32'h0000_0005, 3'b000},
      '{2'd3, UNIT_DIV,  OP_REMU, 32'hFFFF_FFFF, 32'h0000_0010, 32'h0000_000F, 3'b000},
      '{2'd3, UNIT_PIPE, OP_REMU, 32'h0000_0009, 32'h0000_0002, 32'h0000_0000, 3'b001}
   };

   logic                          clk;
   logic                          arst_n;
   logic       [NB_CORES-1:0]     core_req;
   logic       [NB_CORES-1:0]     core_gnt;
   unit_type_e [NB_CORES-1:0]     core_type;
   apu_req_t   [NB_CORES-1:0]     core_data;
   logic       [NB_CORES-1:0]     core_rvalid;
   logic       [NB_CORES-1:0]     core_rready;
   apu_rsp_t   [NB_CORES-1:0]     core_rdata;
   apu_rsp_t   [NB_CORES-1:0]     core_exp;
   int                            checker_errors;
   int                            rsp_count;
   int                            other_errors;
   logic       [15:0]             lfsr;

   shared_apu_cluster DUT
   (
      .clk           ( clk         ),
      .arst_n_i      ( arst_n      ),
      .core_req_i    ( core_req    ),
      .core_gnt_o    ( core_gnt    ),
      .core_type_i   ( core_type   ),
      .core_data_i   ( core_data   ),
      .core_rvalid_o ( core_rvalid ),
      .core_rready_i ( core_rready ),
      .core_rdata_o  ( core_rdata  )
   );

   tb_checker i_tb_checker
   (
      .clk           ( clk            ),
      .arst_n_i      ( arst_n         ),
      .core_req_i    ( core_req       ),
      .core_gnt_i    ( core_gnt       ),
      .core_rvalid_i ( core_rvalid    ),
      .core_rready_i ( core_rready    ),
      .core_rdata_i  ( core_rdata     ),
      .exp_rsp_i     ( core_exp       ),
      .error_count_o ( checker_errors ),
      .rsp_count_o   ( rsp_count      )
   );

   // 16-bit Fibonacci LFSR, taps 16 14 13 11
   function automatic logic [15:0] lfsr_step(input logic [15:0] state);
      logic feedback;
      feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
      return {state[14:0], feedback};
   endfunction

   task automatic wait_grant(input int c);
      logic granted;
      granted = 1'b0;
      for (int n = 0; (n < TIMEOUT_CYCLES) && !granted; n++)
      begin
         @(negedge clk);
         granted = core_gnt[c];
      end
      if (!granted)
      begin
         other_errors++;
         $display("Timeout: core %0d got no grant within %0d cycles", c, TIMEOUT_CYCLES);
      end
      @(posedge clk);
      #DRIVE_DELAY;
   endtask

   // Issues this core's table rows back to back, the next one waits on the held response
   task automatic run_core(input int c);
      for (int i = 0; i < NB_ENTRIES; i++)
      begin
         if (int'(STIM[i].core) == c)
         begin
            core_req[c]            = 1'b1;
            core_type[c]           = STIM[i].utype;
            core_data[c].op        = STIM[i].op;
            core_data[c].operand_a = STIM[i].operand_a;
            core_data[c].operand_b = STIM[i].operand_b;
            core_exp[c].data       = STIM[i].exp_data;
            core_exp[c].flags      = STIM[i].exp_flags;
            wait_grant(c);
         end
      end
      core_req[c] = 1'b0;
   endtask

   task automatic check_idle_after_reset();
      for (int n = 0; n < 2; n++)
      begin
         @(negedge clk);
         if (core_rvalid != '0)
         begin
            other_errors++;
            $display("core_rvalid_o is high after reset with nothing requested");
         end
         if (core_gnt != '0)
         begin
            other_errors++;
            $display("core_gnt_o is high after reset with no request");
         end
      end
      @(posedge clk);
      #DRIVE_DELAY;
   endtask

   task automatic wait_all_responses();
      int n;
      n = 0;
      while ((rsp_count < NB_ENTRIES) && (n < TIMEOUT_CYCLES))
      begin
         @(posedge clk);
         n++;
      end
      if (rsp_count < NB_ENTRIES)
      begin
         other_errors++;
         $display("Timeout: only %0d of %0d responses arrived", rsp_count, NB_ENTRIES);
      end
   endtask

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD/2) clk = ~clk;
   end

   // Random response stalls, one LFSR step per core and cycle
   initial
   begin
      lfsr = LFSR_SEED;
      forever
      begin
         @(posedge clk);
         #DRIVE_DELAY;
         for (int c = 0; c < NB_CORES; c++)
         begin
            lfsr           = lfsr_step(lfsr);
            core_rready[c] = lfsr[0];
         end
      end
   end

   initial
   begin
      int total;
      arst_n       = 1'b0;
      core_req     = '0;
      core_data    = '0;
      core_rready  = '0;
      core_exp     = '0;
      other_errors = 0;
      for (int c = 0; c < NB_CORES; c++)
      begin
         core_type[c] = UNIT_PIPE;
      end

      repeat (RESET_CYCLES) @(posedge clk);
      #DRIVE_DELAY;
      arst_n = 1'b1;
      check_idle_after_reset();

      // All cores at once
      fork
         run_core(0);
         run_core(1);
         run_core(2);
         run_core(3);
      join
      wait_all_responses();

      total = checker_errors + other_errors + DUT.i_tb_assertions.fail_count;
      $display("Errors: %0d checker, %0d timeout or reset, %0d assertion",
               checker_errors, other_errors, DUT.i_tb_assertions.fail_count);
      if (total == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule

// ==== tb.f ====
apu_cluster_pkg.sv
apu_demux.sv
apu_xbar.sv
apu_pipe_unit.sv
apu_div_unit.sv
shared_apu_cluster.sv
tb_checker.sv
tb_assertions.sv
tb_shared_apu_cluster.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the cluster testbench with Verilator, pass only if the log says so
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_shared_apu_cluster -f tb.f \
   && ./obj_dir/Vtb_shared_apu_cluster > sim.log 2>&1 \
   || echo "Build or simulation ended with an error"
cat sim.log 2>/dev/null
grep -qx "Testbench passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
